/* verilog/audioRom_cfg.svh */
`ifndef AUDIO_ROM_CFG_SVH
`define AUDIO_ROM_CFG_SVH

// ----------------------------------------
// Flash layout
// ----------------------------------------

// Page number width, flash address is {page, 8'h00}
`define AR_PAGE_WIDTH 16
// Bytes fetched per page, eight samples
`define AR_PAGE_BYTES 16
// Standard READ command
`define AR_READ_OPCODE 8'h03

// ----------------------------------------
// Read FIFO
// ----------------------------------------
`define AR_FIFO_DEPTH 16
`define AR_FIFO_AW 4

`endif

/* verilog/AudioRomPkg.sv */
package AudioRomPkg;

	// ----------------------------------------
	// Page read sequencer states
	// ----------------------------------------
	typedef enum logic [2:0]
	{
		RrsIdle,
		RrsCmdSend,
		RrsAdrsSend,
		RrsDataRead,
		RrsPushWait,
		RrsCsHold,
		RrsDone
	} rrsState_t;

	// Current owner of the SPI byte engine
	typedef enum logic [1:0] {OwnNone, OwnCpu, OwnSeq} sfmOwner_t;

	// Byte engine phase
	typedef enum logic [1:0] {SpiIdle, SpiShift, SpiFinish} spiPhase_t;

endpackage

/* verilog/SpiFlashByte.sv */
module SpiFlashByte
	import AudioRomPkg::*;
(
	input  logic       sClk,
	input  logic       reset,
	input  logic [7:0] wd,
	input  logic       start,
	input  logic       csCtrl,
	input  logic [7:0] div,
	input  logic       miso,
	output logic       sck,
	output logic       mosi,
	output logic       cs,
	output logic [7:0] rdData,
	output logic       done
);

	spiPhase_t  phase;
	logic [7:0] divCnt;
	logic [3:0] edgeCnt;
	logic [7:0] txReg;
	logic       tick;

	// SCK edge enable, one per div+1 cycles
	assign tick = (phase == SpiShift) && (divCnt == div);
	// MSB always on the pin
	assign mosi = txReg[7];
	// Single cycle, right after the last falling edge
	assign done = (phase == SpiFinish);

	// ----------------------------------------
	// Phase, divider and SCK
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			phase   <= SpiIdle;
			divCnt  <= '0;
			edgeCnt <= '0;
			sck     <= 1'b0;
			cs      <= 1'b1;
		end
		else
		begin
			// Chip select is the master's call
			cs <= csCtrl;
			case (phase)
				SpiIdle:
					if (start)
					begin
						phase   <= SpiShift;
						divCnt  <= '0;
						edgeCnt <= '0;
					end
				SpiShift:
					if (tick)
					begin
						divCnt  <= '0;
						sck     <= ~sck;
						edgeCnt <= edgeCnt + 4'd1;
						// 16th edge is the final fall
						if (edgeCnt == 4'd15)
							phase <= SpiFinish;
					end
					else
						divCnt <= divCnt + 8'd1;
				SpiFinish:
					phase <= SpiIdle;
				default:
					phase <= SpiIdle;
			endcase
		end
	end

	// ----------------------------------------
	// Shift registers
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		// Load on start, shift out on falling SCK
		if ((phase == SpiIdle) && start)
			txReg <= wd;
		else if (tick && sck)
			txReg <= {txReg[6:0], 1'b0};
		// Sample on rising SCK, holds after done
		if (tick && !sck)
			rdData <= {rdData[6:0], miso};
	end

endmodule

/* verilog/SfmBusArbiter.sv */
module SfmBusArbiter
	import AudioRomPkg::*;
(
	input  logic       sClk,
	input  logic       reset,
	input  logic [7:0] cpuWd,
	input  logic       cpuEn,
	input  logic       cpuCsCtrl,
	input  logic       cpuValid,
	input  logic [7:0] seqWd,
	input  logic       seqStart,
	input  logic       seqCsCtrl,
	output logic       cpuDone,
	output logic       seqDone,
	output logic [7:0] spiWd,
	output logic       spiStart,
	output logic       spiCsCtrl,
	input  logic       spiDone
);

	sfmOwner_t owner;
	logic      grantCpu;
	logic      grantSeq;

	// Effective grant, CPU wins a free bus
	assign grantCpu = (owner == OwnCpu) || ((owner == OwnNone) && cpuValid);
	assign grantSeq = (owner == OwnSeq) || ((owner == OwnNone) && !cpuValid && seqStart);

	assign spiWd    = grantCpu ? cpuWd : seqWd;
	assign spiStart = (grantCpu && cpuEn) || (grantSeq && seqStart);
	// Completion only to the owner
	assign cpuDone  = spiDone && (owner == OwnCpu);
	assign seqDone  = spiDone && (owner == OwnSeq);

	// Idle bus keeps any master's low CS low
	always_comb
	begin
		case (owner)
			OwnCpu:  spiCsCtrl = cpuCsCtrl;
			OwnSeq:  spiCsCtrl = seqCsCtrl;
			default: spiCsCtrl = cpuCsCtrl & seqCsCtrl;
		endcase
	end

	// Grant held until the byte completes
	always_ff @(posedge sClk)
	begin
		if (reset)
			owner <= OwnNone;
		else if (owner == OwnNone)
		begin
			if (cpuValid)
				owner <= OwnCpu;
			else if (seqStart)
				owner <= OwnSeq;
		end
		else if (spiDone)
			owner <= OwnNone;
		// CPU walked away without sending a byte
		else if ((owner == OwnCpu) && !cpuValid)
			owner <= OwnNone;
	end

endmodule

/* verilog/AudioRomReadSequence.sv */
`include "audioRom_cfg.svh"

module AudioRomReadSequence
	import AudioRomPkg::*;
(
	input  logic                      sClk,
	input  logic                      reset,
	input  logic                      en,
	input  logic                      cycleEn,
	input  logic [7:0]                csHoldTime,
	input  logic [`AR_PAGE_WIDTH-1:0] startAdrs,
	input  logic [`AR_PAGE_WIDTH-1:0] endAdrs,
	input  logic [7:0]                spiRd,
	input  logic                      spiDone,
	output logic [7:0]                spiWd,
	output logic                      spiStart,
	output logic                      spiCsCtrl,
	output logic                      fifoWe,
	output logic [15:0]               fifoWd,
	input  logic [`AR_FIFO_AW:0]      fifoFree,
	output logic                      done,
	output logic [`AR_PAGE_WIDTH-1:0] adrsAdd
);

	localparam int BcWidth = $clog2(`AR_PAGE_BYTES);
	localparam logic [BcWidth-1:0] LastByte = BcWidth'(`AR_PAGE_BYTES - 1);
	localparam logic [BcWidth-1:0] LastAdrs = BcWidth'(2);
	// Room for the sample in flight plus the next one
	localparam logic [`AR_FIFO_AW:0] MinFree = (`AR_FIFO_AW + 1)'(2);

	rrsState_t          state;
	logic               busy;
	logic [7:0]         holdCnt;
	logic [7:0]         lowByte;
	logic [BcWidth-1:0] byteCnt;
	logic [23:0]        flashAdrs;

	assign flashAdrs = {adrsAdd, 8'h00};
	// CS low for the whole page, wait included
	assign spiCsCtrl = !(state inside {RrsCmdSend, RrsAdrsSend, RrsDataRead, RrsPushWait});

	// Byte to send, address MSB first
	always_comb
	begin
		case (state)
			RrsCmdSend:
				spiWd = `AR_READ_OPCODE;
			RrsAdrsSend:
				case (byteCnt)
					BcWidth'(0): spiWd = flashAdrs[23:16];
					BcWidth'(1): spiWd = flashAdrs[15:8];
					default:     spiWd = flashAdrs[7:0];
				endcase
			// Dummy data while reading
			default:
				spiWd = 8'h00;
		endcase
	end

	// ----------------------------------------
	// Page sequencer
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			state    <= RrsIdle;
			busy     <= 1'b0;
			spiStart <= 1'b0;
			fifoWe   <= 1'b0;
			done     <= 1'b0;
			byteCnt  <= '0;
			holdCnt  <= '0;
			adrsAdd  <= '0;
		end
		else
		begin
			spiStart <= 1'b0;
			fifoWe   <= 1'b0;
			done     <= 1'b0;
			if (spiDone)
				busy <= 1'b0;
			// Disable only between bytes
			if (!en && !busy)
				state <= RrsIdle;
			else
				case (state)
					RrsIdle:
					begin
						state   <= RrsCmdSend;
						adrsAdd <= startAdrs;
					end
					RrsCmdSend:
						if (!busy)
						begin
							spiStart <= 1'b1;
							busy     <= 1'b1;
						end
						else if (spiDone)
						begin
							state   <= RrsAdrsSend;
							byteCnt <= '0;
						end
					RrsAdrsSend:
						if (!busy)
						begin
							spiStart <= 1'b1;
							busy     <= 1'b1;
						end
						else if (spiDone)
						begin
							if (byteCnt == LastAdrs)
							begin
								state   <= RrsDataRead;
								byteCnt <= '0;
							end
							else
								byteCnt <= byteCnt + 1'b1;
						end
					RrsDataRead:
						if (!busy)
						begin
							// Low byte of a sample, check for room first
							if (!byteCnt[0] && (fifoFree < MinFree))
								state <= RrsPushWait;
							else
							begin
								spiStart <= 1'b1;
								busy     <= 1'b1;
							end
						end
						else if (spiDone)
						begin
							fifoWe <= byteCnt[0];
							if (byteCnt == LastByte)
							begin
								state   <= RrsCsHold;
								holdCnt <= '0;
								byteCnt <= '0;
							end
							else
								byteCnt <= byteCnt + 1'b1;
						end
					RrsPushWait:
						if (fifoFree >= MinFree)
							state <= RrsDataRead;
					RrsCsHold:
						// csHoldTime+1 cycles with CS high
						if (holdCnt != csHoldTime)
							holdCnt <= holdCnt + 8'd1;
						else if (adrsAdd != endAdrs)
						begin
							adrsAdd <= adrsAdd + 1'b1;
							state   <= RrsCmdSend;
						end
						else if (cycleEn)
						begin
							adrsAdd <= startAdrs;
							state   <= RrsCmdSend;
						end
						else
						begin
							state <= RrsDone;
							done  <= 1'b1;
						end
					// Parked until en drops
					RrsDone:
						state <= RrsDone;
					default:
						state <= RrsIdle;
				endcase
		end
	end

	// Sample assembly, low byte first
	always_ff @(posedge sClk)
	begin
		if ((state == RrsDataRead) && busy && spiDone)
		begin
			if (byteCnt[0])
				fifoWd <= {spiRd, lowByte};
			else
				lowByte <= spiRd;
		end
	end

endmodule

/* verilog/SampleFifo.sv */
`include "audioRom_cfg.svh"

module SampleFifo
(
	input  logic                 sClk,
	input  logic                 reset,
	input  logic                 we,
	input  logic [15:0]          wd,
	input  logic                 re,
	output logic [15:0]          rd,
	output logic                 rvd,
	output logic                 emp,
	output logic [`AR_FIFO_AW:0] free
);

	localparam logic [`AR_FIFO_AW:0] Depth = (`AR_FIFO_AW + 1)'(`AR_FIFO_DEPTH);

	logic [15:0]             mem [`AR_FIFO_DEPTH];
	logic [`AR_FIFO_AW-1:0]  wrPtr;
	logic [`AR_FIFO_AW-1:0]  rdPtr;
	logic [`AR_FIFO_AW:0]    count;
	logic                    push;
	logic                    pop;

	// Overflow and underflow dropped
	assign push = we && (count != Depth);
	assign pop  = re && !emp;
	assign emp  = (count == '0);
	assign free = Depth - count;

	// ----------------------------------------
	// Pointers and count
	// ----------------------------------------
	always_ff @(posedge sClk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			rvd   <= 1'b0;
		end
		else
		begin
			rvd <= pop;
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Storage and read data, one cycle after re
	always_ff @(posedge sClk)
	begin
		if (push)
			mem[wrPtr] <= wd;
		if (pop)
			rd <= mem[rdPtr];
	end

endmodule

/* verilog/AudioRomRead.sv */
`include "audioRom_cfg.svh"

module AudioRomRead
(
	input  logic                      sClk,
	input  logic                      reset,
	// Serial flash pins
	output logic                      sfmSck,
	output logic                      sfmMosi,
	input  logic                      sfmMiso,
	output logic                      sfmCs,
	// Sample FIFO read side
	output logic [15:0]               rd,
	output logic                      rvd,
	output logic                      emp,
	input  logic                      re,
	// Sequencer control
	input  logic                      sfmEn,
	input  logic                      sfmCycleEn,
	input  logic [7:0]                sfmDiv,
	input  logic [7:0]                sfmCsHoldTime,
	input  logic [`AR_PAGE_WIDTH-1:0] sfmStartAdrs,
	input  logic [`AR_PAGE_WIDTH-1:0] sfmEndAdrs,
	// CPU byte access
	input  logic [7:0]                cpuWd,
	input  logic                      cpuEn,
	input  logic                      cpuCsCtrl,
	input  logic                      cpuValid,
	output logic [7:0]                cpuRd,
	output logic                      cpuDone,
	// Status
	output logic                      sfmDone,
	output logic [`AR_PAGE_WIDTH-1:0] sfmAdrsAdd
);

	logic [7:0]            seqWd;
	logic                  seqStart;
	logic                  seqCsCtrl;
	logic                  seqDone;
	logic [7:0]            spiWd;
	logic                  spiStart;
	logic                  spiCsCtrl;
	logic                  spiDone;
	logic                  fifoWe;
	logic [15:0]           fifoWd;
	logic [`AR_FIFO_AW:0]  fifoFree;

	// ----------------------------------------
	// Page read sequencer and sample FIFO
	// ----------------------------------------
	AudioRomReadSequence sequence0 (
		.sClk(sClk), .reset(reset),
		.en(sfmEn), .cycleEn(sfmCycleEn), .csHoldTime(sfmCsHoldTime),
		.startAdrs(sfmStartAdrs), .endAdrs(sfmEndAdrs),
		// Read data straight from the engine
		.spiRd(cpuRd), .spiDone(seqDone),
		.spiWd(seqWd), .spiStart(seqStart), .spiCsCtrl(seqCsCtrl),
		.fifoWe(fifoWe), .fifoWd(fifoWd), .fifoFree(fifoFree),
		.done(sfmDone), .adrsAdd(sfmAdrsAdd)
	);

	SampleFifo fifo0 (
		.sClk(sClk), .reset(reset),
		.we(fifoWe), .wd(fifoWd),
		.re(re), .rd(rd), .rvd(rvd), .emp(emp), .free(fifoFree)
	);

	// ----------------------------------------
	// Shared SPI byte engine
	// ----------------------------------------
	SfmBusArbiter arbiter0 (
		.sClk(sClk), .reset(reset),
		.cpuWd(cpuWd), .cpuEn(cpuEn), .cpuCsCtrl(cpuCsCtrl), .cpuValid(cpuValid),
		.seqWd(seqWd), .seqStart(seqStart), .seqCsCtrl(seqCsCtrl),
		.cpuDone(cpuDone), .seqDone(seqDone),
		.spiWd(spiWd), .spiStart(spiStart), .spiCsCtrl(spiCsCtrl), .spiDone(spiDone)
	);

	SpiFlashByte spi0 (
		.sClk(sClk), .reset(reset),
		.wd(spiWd), .start(spiStart), .csCtrl(spiCsCtrl), .div(sfmDiv),
		.miso(sfmMiso), .sck(sfmSck), .mosi(sfmMosi), .cs(sfmCs),
		.rdData(cpuRd), .done(spiDone)
	);

endmodule

/* dv/SpiFlashModel.sv */
`include "audioRom_cfg.svh"

module SpiFlashModel
(
	input  logic sck,
	input  logic mosi,
	input  logic cs,
	output logic miso
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0]  rxReg = 8'h00;
	logic [7:0]  txByte = 8'hC2;
	logic [7:0]  opcode = 8'h00;
	logic [2:0]  bitCnt = 3'd0;
	logic [23:0] rdAdrs = 24'h0;
	int          byteIdx = 0;
	// Bytes seen under any opcode other than READ
	logic [7:0]  logBytes [16];
	int          logCount = 0;

	// Flash content rule
	function automatic logic [7:0] romByte(input logic [23:0] a);
		return (a[7:0] ^ a[15:8]) + 8'h5A;
	endfunction

	assign miso = cs ? 1'b0 : txByte[7];

	always @(posedge sck or negedge sck or posedge cs)
	begin
		if (cs)
		begin
			// Released, next transaction starts clean
			bitCnt  = 3'd0;
			byteIdx = 0;
			opcode  = 8'h00;
			txByte  = 8'hC2;
		end
		else if (sck)
		begin
			// Mode 0, MOSI taken on rising SCK
			rxReg  = {rxReg[6:0], mosi};
			bitCnt = bitCnt + 3'd1;
			if (bitCnt == 3'd0)
			begin
				if (byteIdx == 0)
					opcode = rxReg;
				// Address MSB first
				if ((byteIdx >= 1) && (byteIdx <= 3))
					rdAdrs = {rdAdrs[15:0], rxReg};
				if ((opcode != `AR_READ_OPCODE) && (logCount < 16))
				begin
					logBytes[logCount] = rxReg;
					logCount++;
				end
				byteIdx++;
			end
		end
		else
		begin
			// Falling SCK, next MISO bit or next byte
			if (bitCnt != 3'd0)
				txByte = {txByte[6:0], 1'b0};
			else if ((opcode == `AR_READ_OPCODE) && (byteIdx >= 4))
			begin
				txByte = romByte(rdAdrs);
				rdAdrs = rdAdrs + 24'd1;
			end
			else
				txByte = 8'hC2;
		end
	end

endmodule

/* dv/AudioRomRead_checker.sv */
module AudioRomRead_checker
	import AudioRomPkg::*;
(
	input logic sClk,
	input logic reset,
	input logic sfmSck,
	input logic sfmCs,
	input logic rvd,
	input logic re,
	input logic emp,
	input logic sfmDone
);
	timeunit 1ns;
	timeprecision 100ps;

	// SCK parked low outside a transaction
	sckIdle: assert property (@(posedge sClk) disable iff (reset) sfmCs |-> !sfmSck)
		else $error("SCK high while chip select released");

	// Read data only after a pop from a non-empty FIFO
	rvdCause: assert property (@(posedge sClk) disable iff (reset) rvd |-> $past(re && !emp))
		else $error("rvd without a valid pop");

	// Done is a single-cycle pulse
	donePulse: assert property (@(posedge sClk) disable iff (reset) sfmDone |=> !sfmDone)
		else $error("sfmDone high for two cycles");

endmodule

bind AudioRomRead AudioRomRead_checker checker0 (
	.sClk(sClk), .reset(reset), .sfmSck(sfmSck), .sfmCs(sfmCs),
	.rvd(rvd), .re(re), .emp(emp), .sfmDone(sfmDone)
);

/* dv/AudioRomReadTb.sv */
`include "audioRom_cfg.svh"

module AudioRomReadTb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [7:0]  div;
		logic [15:0] startPage;
		logic [15:0] endPage;
		logic        cycleEn;
		logic [7:0]  holdTime;
		logic [7:0]  gapMask;
	} stimRow_t;

	localparam int NumRows = 6;

	logic        sClk = 1'b0;
	logic        reset;
	logic        sfmSck, sfmMosi, sfmMiso, sfmCs;
	logic [15:0] rd;
	logic        rvd, emp, re;
	logic        sfmEn, sfmCycleEn;
	logic [7:0]  sfmDiv, sfmCsHoldTime;
	logic [15:0] sfmStartAdrs, sfmEndAdrs, sfmAdrsAdd;
	logic [7:0]  cpuWd, cpuRd;
	logic        cpuEn, cpuCsCtrl, cpuValid, cpuDone, sfmDone;

	stimRow_t    rows [NumRows];
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	int          limit = 0;
	int          doneTotal = 0;
	logic [31:0] lfsr = 32'h6d94_a597;

	AudioRomRead dut (.*);

	SpiFlashModel flash (.sck(sfmSck), .mosi(sfmMosi), .cs(sfmCs), .miso(sfmMiso));

	initial
	begin
		forever #10 sClk = ~sClk;
	end

	// ----------------------------------------
	// Monitors and timeout
	// ----------------------------------------
	always @(posedge sClk)
	begin
		if (!reset && sfmDone)
			doneTotal++;
		cycles++;
		if (cycles > limit)
		begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// Galois LFSR stepped once per bit
	function automatic logic [7:0] randomBits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return v;
	endfunction

	// Sample k of a page with the high byte at the odd offset
	function automatic logic [15:0] sampleOf(input logic [15:0] page, input int k);
		logic [7:0] off;
		logic [7:0] lo;
		logic [7:0] hi;
		off = 8'(2 * k);
		lo  = (off ^ page[7:0]) + 8'h5A;
		hi  = ((off + 8'd1) ^ page[7:0]) + 8'h5A;
		return {hi, lo};
	endfunction

	// Pages per row times the worst byte time plus pop gaps
	function automatic int timeoutLimit();
		int span;
		int pages;
		int lim;
		lim = 4000;
		for (int i = 0; i < NumRows; i++)
		begin
			span  = int'(rows[i].endPage - rows[i].startPage) + 1;
			pages = rows[i].cycleEn ? 2 * span + 3 : span;
			lim += pages * (`AR_PAGE_BYTES + 4) * 16 * (int'(rows[i].div) + 2);
			lim += pages * 8 * (int'(rows[i].gapMask) + 4);
		end
		return lim;
	endfunction

	// ----------------------------------------
	// CPU byte path
	// ----------------------------------------
	task automatic cpuByte(input logic [7:0] b);
		cpuWd = b;
		cpuEn = 1'b1;
		@(negedge sClk);
		cpuEn = 1'b0;
		while (!cpuDone)
			@(negedge sClk);
		checks++;
		if (cpuRd !== 8'hC2)
		begin
			errors++;
			$display("[ERROR] cpu byte %h readback expected c2 actual %h", b, cpuRd);
		end
		// Engine passes through Finish before the next start
		@(negedge sClk);
	endtask

	task automatic cpuAccess();
		sfmDiv    = 8'd1;
		cpuValid  = 1'b1;
		cpuCsCtrl = 1'b0;
		@(negedge sClk);
		cpuByte(8'h06);
		cpuByte(8'h9F);
		cpuCsCtrl = 1'b1;
		cpuValid  = 1'b0;
		@(negedge sClk);
		checks++;
		if ((flash.logCount !== 2) || (flash.logBytes[0] !== 8'h06)
			|| (flash.logBytes[1] !== 8'h9F))
		begin
			errors++;
			$display("[ERROR] cpu flash log expected 2 bytes 06 9f actual %0d bytes %h %h",
				flash.logCount, flash.logBytes[0], flash.logBytes[1]);
		end
	endtask

	// ----------------------------------------
	// One table row
	// ----------------------------------------
	task automatic runRow(input int idx);
		stimRow_t    r;
		int          span;
		int          total;
		int          doneBase;
		logic [7:0]  gap;
		logic [15:0] exp;
		r        = rows[idx];
		span     = int'(r.endPage - r.startPage) + 1;
		// Cycle rows run two loops and one page past the wrap
		total    = r.cycleEn ? span * 16 + 8 : span * 8;
		doneBase = doneTotal;
		sfmDiv        = r.div;
		sfmStartAdrs  = r.startPage;
		sfmEndAdrs    = r.endPage;
		sfmCycleEn    = r.cycleEn;
		sfmCsHoldTime = r.holdTime;
		sfmEn         = 1'b1;
		for (int i = 0; i < total; i++)
		begin
			gap = randomBits(8) & r.gapMask;
			repeat (gap)
				@(negedge sClk);
			while (emp)
				@(negedge sClk);
			re = 1'b1;
			@(negedge sClk);
			re  = 1'b0;
			exp = sampleOf(r.startPage + 16'((i / 8) % span), i % 8);
			checks++;
			if (!rvd)
			begin
				errors++;
				$display("Row %0d: no read valid after pop %0d", idx, i);
			end
			else if (rd !== exp)
			begin
				errors++;
				$display("[ERROR] row %0d sample %0d expected %h actual %h", idx, i, exp, rd);
			end
		end
		if (!r.cycleEn)
		begin
			while (doneTotal == doneBase)
				@(negedge sClk);
			checks++;
			if (sfmAdrsAdd !== r.endPage)
			begin
				errors++;
				$display("[ERROR] row %0d adrsAdd expected %h actual %h",
					idx, r.endPage, sfmAdrsAdd);
			end
			checks++;
			if (!emp)
			begin
				errors++;
				$display("Row %0d: FIFO still holds samples after the last page", idx);
			end
		end
		// Stop and let the last byte finish before the FIFO flush
		sfmEn = 1'b0;
		@(negedge sClk);
		while (!sfmCs)
			@(negedge sClk);
		@(negedge sClk);
		while (!emp)
		begin
			re = 1'b1;
			@(negedge sClk);
		end
		re = 1'b0;
		checks++;
		if ((doneTotal - doneBase) !== (r.cycleEn ? 0 : 1))
		begin
			errors++;
			$display("[ERROR] row %0d done pulses expected %0d actual %0d",
				idx, r.cycleEn ? 0 : 1, doneTotal - doneBase);
		end
		@(negedge sClk);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		reset         = 1'b1;
		re            = 1'b0;
		sfmEn         = 1'b0;
		sfmCycleEn    = 1'b0;
		sfmDiv        = 8'd0;
		sfmCsHoldTime = 8'd0;
		sfmStartAdrs  = 16'h0;
		sfmEndAdrs    = 16'h0;
		cpuWd         = 8'h00;
		cpuEn         = 1'b0;
		cpuCsCtrl     = 1'b1;
		cpuValid      = 1'b0;
		// div, start, end, cycle, hold, gap mask
		rows = '{
			'{8'd0, 16'h0010, 16'h0012, 1'b0, 8'd2, 8'h00},
			'{8'd1, 16'h01A3, 16'h01A5, 1'b0, 8'd0, 8'h0F},
			'{8'd3, 16'h0200, 16'h0201, 1'b0, 8'd5, 8'h07},
			// Slow consumer, the FIFO fills and the sequencer stalls
			'{8'd0, 16'h0005, 16'h000C, 1'b0, 8'd1, 8'hFF},
			'{8'd0, 16'h0030, 16'h0031, 1'b1, 8'd1, 8'h1F},
			'{8'd1, 16'h00FF, 16'h0100, 1'b1, 8'd3, 8'h3F}
		};
		limit = timeoutLimit();
		repeat (5)
			@(negedge sClk);
		reset = 1'b0;
		// cs, sck, emp, rvd, done, cpu done
		checks++;
		if ({sfmCs, sfmSck, emp, rvd, sfmDone, cpuDone} !== 6'b101000)
		begin
			errors++;
			$display("[ERROR] reset state expected 101000 actual %b",
				{sfmCs, sfmSck, emp, rvd, sfmDone, cpuDone});
		end
		cpuAccess();
		for (int i = 0; i < NumRows; i++)
			runRow(i);
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* src.f */
+incdir+verilog
verilog/AudioRomPkg.sv
verilog/SpiFlashByte.sv
verilog/SfmBusArbiter.sv
verilog/AudioRomReadSequence.sv
verilog/SampleFifo.sv
verilog/AudioRomRead.sv
dv/SpiFlashModel.sv
dv/AudioRomRead_checker.sv
dv/AudioRomReadTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f src.f \
	--top-module AudioRomReadTb \
	--Mdir obj_dir

output=$(./obj_dir/VAudioRomReadTb 2>&1) || true
echo "$output"

if grep -qx "TEST PASS" <<< "$output"; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1
